// ==== hw/rom_pkg.sv ====
package rom_pkg;

    // SDRAM geometry
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 16;

    // Client address widths
    // Main and sound count bytes, scroll counts 32-bit rows
    localparam int MAIN_AW = 16;
    localparam int SND_AW  = 13;
    localparam int SCR_AW  = 13;

    // Region offsets in SDRAM words, main ROM sits at word 0
    // Main ROM is 64 kB, i.e. 32k words
    localparam logic [SDRAM_AW-1:0] SND_START = 22'h00_8000;
    // Sound ROM is 8 kB
    localparam logic [SDRAM_AW-1:0] SCR_START = 22'h00_9000;
    // Scroll ROM is 8k rows of 32 bits
    localparam logic [SDRAM_AW-1:0] PCM_START = 22'h00_D000;

    // Colour PROMs follow a 64 kB PCM region, as an ioctl byte address
    localparam logic [24:0] PROM_START = 25'h002_A000;

    // Slot indices, lower index wins arbitration
    localparam int SLOTS     = 3;
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_SND  = 1;
    localparam int SLOT_SCR  = 2;

    // Slot payloads
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] gfx_word_t;

endpackage

// ==== hw/sdram_port_if.sv ====
`timescale 1ns/1ps

interface sdram_port_if import rom_pkg::*; ();

    // Request side, held by the slot until ack
    logic                req;
    logic [SDRAM_AW-1:0] addr;

    // Burst side, routed back by the arbiter
    logic                ack;
    logic                dst;
    logic                rdy;
    logic [SDRAM_DW-1:0] data;

    modport slot (
        output req,
        output addr,
        input  ack,
        input  dst,
        input  rdy,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output ack,
        output dst,
        output rdy,
        output data
    );

endinterface

// ==== hw/rom_dwnld.sv ====
`timescale 1ns/1ps

module rom_dwnld import rom_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    // ioctl byte stream
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    // SDRAM programming
    input  logic                sdram_ack,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    // Colour PROM strobe
    output logic                prom_we
);

    logic                is_prom;
    logic                in_gfx;
    logic                wr_en;
    logic [SDRAM_AW-1:0] word_addr;
    logic [24:0]         prom_offset;
    logic [7:0]          gfx_byte;

    assign wr_en       = ioctl_wr && downloading;
    assign is_prom     = ioctl_addr >= PROM_START;
    assign prom_offset = ioctl_addr - PROM_START;

    // Two bytes per SDRAM word
    assign word_addr = ioctl_addr[SDRAM_AW:1];

    // Scroll graphics are stored nibble swapped
    assign in_gfx   = word_addr >= SCR_START && word_addr < PCM_START;
    assign gfx_byte = in_gfx ? {ioctl_dout[3:0], ioctl_dout[7:4]} : ioctl_dout;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (wr_en) begin
                if (is_prom) begin
                    prom_we <= 1'b1;
                end else begin
                    prog_we <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (is_prom) begin
                // PROM offset travels on the programming address bus
                prog_addr <= prom_offset[SDRAM_AW-1:0];
                prog_data <= ioctl_dout;
            end else begin
                prog_addr <= word_addr;
                prog_data <= gfx_byte;
                // Active low lanes, even bytes go to the upper half
                prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
            end
        end
    end

endmodule

// ==== hw/rom_slot.sv ====
`timescale 1ns/1ps

module rom_slot import rom_pkg::*; #(
    parameter type                 data_t = byte_t,
    parameter int                  AW     = 16,
    parameter logic [SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output data_t         data,
    output logic          ok,
    sdram_port_if.slot    port
);

    // Payloads wider than one word take the whole burst
    localparam bit WIDE = $bits(data_t) > SDRAM_DW;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        BURST
    } state_t;

    state_t              state;
    logic                valid;
    logic                second;
    logic                hit;
    logic [AW-1:0]       tag;
    logic [AW-1:0]       tag_addr;
    logic [AW-1:0]       tag_pend;
    logic [SDRAM_AW-1:0] addr_ext;
    logic [SDRAM_AW-1:0] word_addr;
    logic [SDRAM_AW-1:0] req_addr;
    logic [SDRAM_DW-1:0] word0;
    logic [SDRAM_DW-1:0] word1;

    // Byte slots share one tag for both bytes of a word
    assign tag_addr = WIDE ? addr : {addr[AW-1:1], 1'b0};
    assign addr_ext = SDRAM_AW'(addr);
    assign word_addr = WIDE ? OFFSET + (addr_ext << 1) : OFFSET + (addr_ext >> 1);

    assign hit = valid && tag == tag_addr;
    assign ok  = cs && hit;

    assign port.req  = state == REQ;
    assign port.addr = req_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            valid  <= 1'b0;
            second <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cs && !hit) begin
                        // Old data is about to be overwritten
                        valid <= 1'b0;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (port.ack) begin
                        state <= BURST;
                    end
                end
                default: begin
                    if (port.dst) begin
                        second <= 1'b1;
                    end
                    if (port.rdy) begin
                        valid  <= 1'b1;
                        second <= 1'b0;
                        state  <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cs && !hit) begin
            req_addr <= word_addr;
            tag_pend <= tag_addr;
        end
        if (state == BURST && port.dst) begin
            if (!second) begin
                word0 <= port.data;
            end else if (WIDE) begin
                word1 <= port.data;
            end
        end
        if (state == BURST && port.rdy) begin
            tag <= tag_pend;
        end
    end

    generate
        if (WIDE) begin : g_wide
            // First word on top
            assign data = data_t'({word0, word1});
        end else begin : g_byte
            assign data = data_t'(addr[0] ? word0[7:0] : word0[15:8]);
        end
    endgenerate

endmodule

// ==== hw/sdram_arbiter.sv ====
`timescale 1ns/1ps

module sdram_arbiter import rom_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    // SDRAM side
    input  logic [SDRAM_DW-1:0] data_read,
    input  logic                sdram_ack,
    input  logic                data_dst,
    input  logic                data_rdy,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    // ROM slots
    sdram_port_if.arbiter       ports [SLOTS]
);

    localparam int IW = $clog2(SLOTS);

    logic [SLOTS-1:0]    req_vec;
    logic [SDRAM_AW-1:0] addr_vec [SLOTS];
    logic [IW-1:0]       owner;
    logic [IW-1:0]       pick;
    logic                busy;

    generate
        for (genvar i = 0; i < SLOTS; i++) begin : g_port
            logic owned;

            assign owned         = busy && owner == IW'(i);
            assign req_vec[i]    = ports[i].req;
            assign addr_vec[i]   = ports[i].addr;
            assign ports[i].ack  = owned && sdram_ack;
            assign ports[i].dst  = owned && data_dst;
            assign ports[i].rdy  = owned && data_rdy;
            // Data bus is shared, the strobes pick the receiver
            assign ports[i].data = data_read;
        end
    endgenerate

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                pick = IW'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            owner <= '0;
        end else begin
            if (!busy) begin
                // Requests wait here while a download runs
                if (!downloading && |req_vec) begin
                    busy  <= 1'b1;
                    owner <= pick;
                end
            end else if (data_rdy) begin
                busy <= 1'b0;
            end
        end
    end

    // The owner drops req after ack, which ends the SDRAM request too
    assign sdram_req  = busy && req_vec[owner];
    assign sdram_addr = addr_vec[owner];

endmodule

// ==== hw/rom_top.sv ====
`timescale 1ns/1ps

module rom_top import rom_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    // ioctl download
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    output logic                prom_we,
    // Main CPU ROM
    input  logic                main_cs,
    input  logic [MAIN_AW-1:0]  main_addr,
    output byte_t               main_data,
    output logic                main_ok,
    // Sound CPU ROM
    input  logic                snd_cs,
    input  logic [SND_AW-1:0]   snd_addr,
    output byte_t               snd_data,
    output logic                snd_ok,
    // Scroll graphics ROM
    input  logic                scr_cs,
    input  logic [SCR_AW-1:0]   scr_addr,
    output gfx_word_t           scr_data,
    output logic                scr_ok,
    // SDRAM
    input  logic                sdram_ack,
    input  logic                data_dst,
    input  logic                data_rdy,
    input  logic [SDRAM_DW-1:0] data_read,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr
);

    sdram_port_if slot_if [SLOTS] ();

    rom_dwnld u_dwnld (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(
        .data_t (byte_t),
        .AW     (MAIN_AW),
        .OFFSET ('0)
    ) u_main (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (main_cs),
        .addr   (main_addr),
        .data   (main_data),
        .ok     (main_ok),
        .port   (slot_if[SLOT_MAIN])
    );

    rom_slot #(
        .data_t (byte_t),
        .AW     (SND_AW),
        .OFFSET (SND_START)
    ) u_snd (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (snd_cs),
        .addr   (snd_addr),
        .data   (snd_data),
        .ok     (snd_ok),
        .port   (slot_if[SLOT_SND])
    );

    // Scroll rows come as a two-word burst
    rom_slot #(
        .data_t (gfx_word_t),
        .AW     (SCR_AW),
        .OFFSET (SCR_START)
    ) u_scr (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (scr_cs),
        .addr   (scr_addr),
        .data   (scr_data),
        .ok     (scr_ok),
        .port   (slot_if[SLOT_SCR])
    );

    sdram_arbiter u_arb (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .data_read   (data_read),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .ports       (slot_if)
    );

endmodule

// ==== bench/rom_checker.sv ====
`timescale 1ns/1ps

module rom_checker import rom_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    input  logic [SDRAM_AW-1:0] prog_addr,
    input  logic [7:0]          prog_data,
    input  logic [1:0]          prog_mask,
    input  logic                prog_we,
    input  logic                prom_we,
    // Slot signals packed by slot index
    input  logic [SLOTS-1:0]    cs,
    input  logic [SLOTS-1:0]    ok,
    input  logic [SLOTS*16-1:0] addrs,
    input  logic [SLOTS*32-1:0] datas,
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_ack,
    output int                  value_errors,
    output int                  event_errors
);

    int                  n_value = 0;
    int                  n_event = 0;
    logic                wr_seen;
    logic                wr_prom;
    logic                prog_hold;
    logic [24:0]         wr_addr;
    logic [7:0]          wr_data;
    logic [SLOTS-1:0]    known;
    logic [SLOTS-1:0]    pend;
    logic [SLOTS-1:0]    acked;
    logic [SDRAM_AW-1:0] last_word [SLOTS];

    assign value_errors = n_value;
    assign event_errors = n_event;

    // Same hash as the SDRAM model
    function automatic logic [15:0] mem_word(input logic [SDRAM_AW-1:0] a);
        logic [31:0] h;
        h = {10'd0, a} * 32'h9e37_79b1;
        return h[31:16] ^ h[15:0];
    endfunction

    // Graphics bytes are stored nibble swapped
    function automatic logic [7:0] prog_byte(input logic [24:0] a, input logic [7:0] d);
        logic [24:0] w;
        w = a >> 1;
        if (a < PROM_START && w >= 25'(SCR_START) && w < 25'(PCM_START)) begin
            return {d[3:0], d[7:4]};
        end
        return d;
    endfunction

    function automatic logic [SDRAM_AW-1:0] word_of(input int s, input logic [15:0] a);
        case (s)
            SLOT_MAIN: return SDRAM_AW'(a >> 1);
            SLOT_SND:  return SND_START + SDRAM_AW'(a >> 1);
            default:   return SCR_START + (SDRAM_AW'(a) << 1);
        endcase
    endfunction

    function automatic logic [31:0] data_of(input int s, input logic [15:0] a);
        logic [SDRAM_AW-1:0] w;
        logic [15:0]         hi;
        logic [15:0]         lo;
        w  = word_of(s, a);
        hi = mem_word(w);
        lo = mem_word(w + 22'd1);
        if (s == SLOT_SCR) begin
            return {hi, lo};
        end
        return a[0] ? {24'd0, hi[7:0]} : {24'd0, hi[15:8]};
    endfunction

    function automatic string data_name(input int s);
        case (s)
            SLOT_MAIN: return "main_data";
            SLOT_SND:  return "snd_data";
            default:   return "scr_data";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s = %h, expected %h at %0t", name, got, exp, $time);
            n_value++;
        end
    endtask

    task automatic report_event(input string what);
        $display("%s at %0t", what, $time);
        n_event++;
    endtask

    // Compare once per cycle
    always @(negedge clk) begin : compare
        int own;
        if (!arst_n) begin
            check_value("sdram_req", 32'(sdram_req), 32'd0);
            check_value("prog_we", 32'(prog_we), 32'd0);
            check_value("prom_we", 32'(prom_we), 32'd0);
            check_value("main_ok", 32'(ok[SLOT_MAIN]), 32'd0);
            check_value("snd_ok", 32'(ok[SLOT_SND]), 32'd0);
            check_value("scr_ok", 32'(ok[SLOT_SCR]), 32'd0);
            wr_seen   = 1'b0;
            prog_hold = 1'b0;
            known     = '0;
            pend      = '0;
            acked     = '0;
        end else begin
            // Download outputs one cycle after the strobe
            check_value("prom_we", 32'(prom_we), 32'(wr_seen && wr_prom));
            if (wr_seen) begin
                check_value("prog_addr", 32'(prog_addr),
                            wr_prom ? 32'(wr_addr - PROM_START) : 32'(wr_addr >> 1));
                check_value("prog_data", 32'(prog_data), 32'(wr_data));
                check_value("prog_we", 32'(prog_we), 32'(!wr_prom));
                if (!wr_prom) begin
                    check_value("prog_mask", 32'(prog_mask), wr_addr[0] ? 32'h2 : 32'h1);
                end
                prog_hold = !wr_prom;
            end else if (prog_hold) begin
                check_value("prog_we", 32'(prog_we), 32'd1);
                if (sdram_ack) begin
                    prog_hold = 1'b0;
                end
            end else begin
                check_value("prog_we", 32'(prog_we), 32'd0);
            end
            wr_seen = ioctl_wr && downloading;
            wr_prom = ioctl_addr >= PROM_START;
            wr_addr = ioctl_addr;
            wr_data = prog_byte(ioctl_addr, ioctl_dout);

            if (downloading && sdram_req) begin
                report_event("SDRAM request raised during a download");
            end

            for (int s = 0; s < SLOTS; s++) begin
                if (ok[s]) begin
                    check_value(data_name(s), datas[s*32 +: 32],
                                data_of(s, addrs[s*16 +: 16]));
                    last_word[s] = word_of(s, addrs[s*16 +: 16]);
                    known[s]     = 1'b1;
                    pend[s]      = 1'b0;
                    acked[s]     = 1'b0;
                end else if (cs[s]) begin
                    if (known[s] && last_word[s] == word_of(s, addrs[s*16 +: 16])) begin
                        report_event($sformatf("Slot %0d gave no ok on a cached word", s));
                    end
                    pend[s] = 1'b1;
                end
            end

            // Lowest waiting slot must own each SDRAM access
            if (sdram_req && sdram_ack) begin
                own = -1;
                for (int s = SLOTS - 1; s >= 0; s--) begin
                    if (pend[s] && !acked[s]) begin
                        own = s;
                    end
                end
                if (own < 0) begin
                    report_event("SDRAM request acknowledged with no slot waiting for data");
                end else begin
                    check_value("sdram_addr", 32'(sdram_addr),
                                32'(word_of(own, addrs[own*16 +: 16])));
                    acked[own] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== bench/rom_tb.sv ====
`timescale 1ns/1ps

module rom_tb import rom_pkg::*; ();

    // Four times the expected length of the run
    localparam int LIMIT = 4 * (64 * 10 + 150 * 12);

    logic                clk;
    logic                arst_n;
    logic                downloading;
    logic [24:0]         ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic [SDRAM_AW-1:0] prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    logic                prom_we;
    logic                main_cs;
    logic [MAIN_AW-1:0]  main_addr;
    byte_t               main_data;
    logic                main_ok;
    logic                snd_cs;
    logic [SND_AW-1:0]   snd_addr;
    byte_t               snd_data;
    logic                snd_ok;
    logic                scr_cs;
    logic [SCR_AW-1:0]   scr_addr;
    gfx_word_t           scr_data;
    logic                scr_ok;
    logic                sdram_ack;
    logic                data_dst;
    logic                data_rdy;
    logic [SDRAM_DW-1:0] data_read;
    logic                sdram_req;
    logic [SDRAM_AW-1:0] sdram_addr;
    int                  value_errors;
    int                  event_errors;
    int                  cycles = 0;
    logic [31:0]         rnd = 32'h8f38e04d;

    rom_top dut_i (.*);

    rom_checker chk_i (
        .*,
        .cs    ({scr_cs, snd_cs, main_cs}),
        .ok    ({scr_ok, snd_ok, main_ok}),
        .addrs ({3'b000, scr_addr, 3'b000, snd_addr, main_addr}),
        .datas ({scr_data, 24'd0, snd_data, 24'd0, main_data})
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [15:0] mem_word(input logic [SDRAM_AW-1:0] a);
        logic [31:0] h;
        h = {10'd0, a} * 32'h9e37_79b1;
        return h[31:16] ^ h[15:0];
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // SDRAM model, ack two cycles after the request, then a two-word burst
    initial begin : sdram_model
        logic [SDRAM_AW-1:0] a;
        logic                burst;
        sdram_ack <= 1'b0;
        data_dst  <= 1'b0;
        data_rdy  <= 1'b0;
        data_read <= '0;
        forever begin
            @(negedge clk);
            if (arst_n && (sdram_req || prog_we)) begin
                a     = sdram_addr;
                burst = sdram_req;
                repeat (2) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                if (burst) begin
                    @(posedge clk);
                    data_dst  <= 1'b1;
                    data_read <= mem_word(a);
                    @(posedge clk);
                    data_dst  <= 1'b0;
                    @(posedge clk);
                    data_dst  <= 1'b1;
                    data_rdy  <= 1'b1;
                    data_read <= mem_word(a + 22'd1);
                    @(posedge clk);
                    data_dst  <= 1'b0;
                    data_rdy  <= 1'b0;
                end
            end
        end
    end

    // Cycles through main, sound, scroll and PROM bytes
    task automatic download_byte(input int i);
        logic [24:0] a;
        rnd = xorshift(rnd);
        case (i % 4)
            0:       a = 25'(rnd[15:0]);
            1:       a = 25'(2 * SND_START) + 25'(rnd[12:0]);
            2:       a = 25'(2 * SCR_START) + 25'(rnd[14:0]);
            default: a = PROM_START + 25'(rnd[7:0]);
        endcase
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_dout <= rnd[23:16];
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic wait_ok(input logic [SLOTS-1:0] mask);
        logic [SLOTS-1:0] ok_v;
        do begin
            @(negedge clk);
            ok_v = {scr_ok, snd_ok, main_ok};
        end while ((ok_v & mask) != mask);
    endtask

    task automatic release_cs();
        @(posedge clk);
        main_cs <= 1'b0;
        snd_cs  <= 1'b0;
        scr_cs  <= 1'b0;
    endtask

    task automatic fetch(input int s, input logic [15:0] a);
        @(posedge clk);
        if (s == SLOT_MAIN) begin
            main_cs   <= 1'b1;
            main_addr <= a;
        end else if (s == SLOT_SND) begin
            snd_cs   <= 1'b1;
            snd_addr <= a[SND_AW-1:0];
        end else begin
            scr_cs   <= 1'b1;
            scr_addr <= a[SCR_AW-1:0];
        end
        wait_ok(3'b001 << s);
        release_cs();
    endtask

    initial begin : stimulus
        logic [15:0] a;
        arst_n      <= 1'b0;
        downloading <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_dout  <= '0;
        ioctl_wr    <= 1'b0;
        main_cs     <= 1'b0;
        main_addr   <= '0;
        snd_cs      <= 1'b0;
        snd_addr    <= '0;
        scr_cs      <= 1'b0;
        scr_addr    <= '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // Main slot waits through the whole download
        downloading <= 1'b1;
        main_cs     <= 1'b1;
        main_addr   <= 16'h1234;
        for (int i = 0; i < 64; i++) begin
            download_byte(i);
        end
        downloading <= 1'b0;
        wait_ok(3'b001);
        release_cs();
        // Each miss is followed by a hit on the same word
        for (int i = 0; i < 24; i++) begin
            rnd = xorshift(rnd);
            a   = rnd[15:0];
            fetch(SLOT_MAIN, a);
            fetch(SLOT_MAIN, a ^ 16'd1);
            fetch(SLOT_SND, a >> 3);
            fetch(SLOT_SND, (a >> 3) ^ 16'd1);
            fetch(SLOT_SCR, rnd[31:16]);
            fetch(SLOT_SCR, rnd[31:16]);
        end
        // All three slots miss together
        for (int i = 0; i < 2; i++) begin
            rnd = xorshift(rnd);
            @(posedge clk);
            main_cs   <= 1'b1;
            snd_cs    <= 1'b1;
            scr_cs    <= 1'b1;
            main_addr <= rnd[15:0];
            snd_addr  <= rnd[28:16];
            scr_addr  <= rnd[31:19];
            wait_ok(3'b111);
            release_cs();
        end
        repeat (4) @(posedge clk);
        $display("Checks done: %0d value errors, %0d other errors", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/rom_pkg.sv
hw/sdram_port_if.sv
hw/rom_dwnld.sv
hw/rom_slot.sv
hw/sdram_arbiter.sv
hw/rom_top.sv
bench/rom_checker.sv
bench/rom_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build, run, then look for the pass message in the log
rm -f sim.log \
    && verilator --binary --timing -f compile.f --top-module rom_tb -o rom_sim \
    && ./obj_dir/rom_sim | tee sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
